// ==== src/lsq_pkg.sv ====
// Queue-side sizes and types for the load/store queue.
// Modules import this inside their body; ports name the types by scope.
package lsq_pkg;

  localparam int LSQ_DEPTH = 8;
  localparam int PTR_W     = 3;
  localparam int TAG_W     = 5;
  localparam int DATA_W    = 32;

  typedef logic [TAG_W-1:0] rob_tag_t;

  // One dispatch slot, in program order
  typedef struct packed {
    logic     valid;
    logic     is_load;
    rob_tag_t tag;
  } dispatch_t;

  // Address and store data from one execute port
  typedef struct packed {
    logic              valid;
    rob_tag_t          tag;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } ex_wb_t;

  // Tag retiring at one ROB head port
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
  } rob_head_t;

  typedef struct packed {
    logic              valid;
    logic              is_load;
    rob_tag_t          tag;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              addr_ready;
    logic              committed;
  } lsq_entry_t;

  typedef struct packed {
    logic              valid;
    rob_tag_t          tag;
    logic [DATA_W-1:0] data;
  } load_result_t;

endpackage

// ==== src/mem_bus_pkg.sv ====
// Data memory request and response types.
// The request uses valid/ready; the response valid travels beside it.
package mem_bus_pkg;

  //////////////////////////////
  // Command
  //////////////////////////////

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_cmd_e;

  //////////////////////////////
  // Channels
  //////////////////////////////

  typedef struct packed {
    mem_cmd_e                   cmd;
    logic [lsq_pkg::DATA_W-1:0] addr;
    // Ignored for loads
    logic [lsq_pkg::DATA_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [lsq_pkg::DATA_W-1:0] data;
  } mem_resp_t;

endpackage

// ==== src/lsq_entry.sv ====
// One load/store queue slot.
// Filled from a dispatch slot, completed by an execute port, marked
// committed by a ROB head match; clear empties it.
module lsq_entry (
  input  logic                clock,
  input  logic                reset,
  input  logic                clear,
  input  logic                load_slot0,
  input  logic                load_slot1,
  input  lsq_pkg::dispatch_t  dispatch [2],
  input  lsq_pkg::ex_wb_t     ex_wb [2],
  input  lsq_pkg::rob_head_t  rob_head [2],
  output lsq_pkg::lsq_entry_t entry
);
  import lsq_pkg::*;

  logic              valid_q;
  logic              addr_ready_q;
  logic              committed_q;
  logic              is_load_q;
  rob_tag_t          tag_q;
  logic [DATA_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;

  dispatch_t         disp_sel;
  logic              take;
  logic              next_valid;
  logic              next_is_load;
  rob_tag_t          next_tag;
  logic [1:0]        wb_hit;
  logic              head_hit;
  logic              next_addr_ready;
  logic              next_committed;

  assign take         = load_slot0 | load_slot1;
  assign disp_sel     = load_slot0 ? dispatch[0] : dispatch[1];
  assign next_valid   = take | valid_q;
  assign next_is_load = take ? disp_sel.is_load : is_load_q;
  assign next_tag     = take ? disp_sel.tag : tag_q;

  // Match on the incoming tag so a same-cycle writeback is caught
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      wb_hit[p] = ex_wb[p].valid && next_valid && (ex_wb[p].tag == next_tag);
    end
  end

  assign head_hit = (rob_head[0].valid && (rob_head[0].tag == next_tag)) ||
                    (rob_head[1].valid && (rob_head[1].tag == next_tag));

  assign next_addr_ready = (|wb_hit) | (addr_ready_q & ~take);

  // Loads only need an address to be issuable
  assign next_committed = next_valid && next_addr_ready &&
                          ((committed_q && !take) || next_is_load || head_hit);

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      valid_q      <= 1'b0;
      addr_ready_q <= 1'b0;
      committed_q  <= 1'b0;
    end else begin
      valid_q      <= next_valid;
      addr_ready_q <= next_addr_ready;
      committed_q  <= next_committed;
    end
  end

  // Port 0 wins when both execute ports carry this tag
  always_ff @(posedge clock) begin
    if (take) begin
      is_load_q <= disp_sel.is_load;
      tag_q     <= disp_sel.tag;
    end
    if (wb_hit[0]) begin
      addr_q <= ex_wb[0].addr;
      data_q <= ex_wb[0].data;
    end else if (wb_hit[1]) begin
      addr_q <= ex_wb[1].addr;
      data_q <= ex_wb[1].data;
    end
  end

  assign entry.valid      = valid_q;
  assign entry.is_load    = is_load_q;
  assign entry.tag        = tag_q;
  assign entry.addr       = addr_q;
  assign entry.data       = data_q;
  assign entry.addr_ready = addr_ready_q;
  assign entry.committed  = committed_q;

endmodule

// ==== src/lsq_queue.sv ====
// Circular queue of eight slots with head, tail and a committed-store count.
// Dispatch fills from the tail, retire empties the head, and a flush
// drops everything past the last committed store.
module lsq_queue (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  logic                retire,
  input  lsq_pkg::dispatch_t  dispatch [2],
  input  lsq_pkg::ex_wb_t     ex_wb [2],
  input  lsq_pkg::rob_head_t  rob_head [2],
  output logic                dispatch_ready,
  output lsq_pkg::lsq_entry_t head_entry
);
  import lsq_pkg::*;

  lsq_entry_t           entries [LSQ_DEPTH];
  logic [LSQ_DEPTH-1:0] clear;
  logic [LSQ_DEPTH-1:0] load_slot0;
  logic [LSQ_DEPTH-1:0] load_slot1;
  logic [PTR_W-1:0]     head;
  logic [PTR_W-1:0]     tail;
  logic [PTR_W:0]       count;
  logic [PTR_W:0]       commit_cnt;
  logic [PTR_W-1:0]     commit_ptr;
  logic [PTR_W-1:0]     commit_nxt;
  logic [PTR_W-1:0]     slot1_ptr;
  logic                 disp0;
  logic                 disp1;
  logic [PTR_W:0]       n_disp;
  logic                 pass0;
  logic                 pass1;
  logic [PTR_W:0]       cut;
  logic                 keep_head;

  //////////////////////////////
  // Dispatch steering
  //////////////////////////////

  // Wrong-path dispatch in the flush cycle is dropped
  assign disp0     = dispatch[0].valid & ~flush;
  assign disp1     = dispatch[1].valid & ~flush;
  assign n_disp    = (PTR_W+1)'(disp0) + (PTR_W+1)'(disp1);
  // A lone slot 1 goes straight to the tail
  assign slot1_ptr = disp0 ? tail + PTR_W'(1) : tail;

  //////////////////////////////
  // Commit pointer
  //////////////////////////////

  assign commit_ptr = head + commit_cnt[PTR_W-1:0];
  assign commit_nxt = commit_ptr + PTR_W'(1);

  // Step over committed stores, or over a head that leaves this cycle
  assign pass0 = (commit_cnt < count) && entries[commit_ptr].valid &&
                 ((!entries[commit_ptr].is_load && entries[commit_ptr].committed) ||
                  (retire && (commit_cnt == '0)));
  assign pass1 = pass0 && ((commit_cnt + 1) < count) && entries[commit_nxt].valid &&
                 !entries[commit_nxt].is_load && entries[commit_nxt].committed;
  assign cut   = commit_cnt + (PTR_W+1)'(pass0) + (PTR_W+1)'(pass1);

  // A ready load at the head may already be at memory, so it survives a flush
  assign keep_head = head_entry.valid && head_entry.is_load && head_entry.addr_ready &&
                     (cut == '0) && !retire;

  for (genvar i = 0; i < LSQ_DEPTH; i++) begin : g_slot
    logic [PTR_W-1:0] offset;

    assign offset        = PTR_W'(i) - head;
    assign load_slot0[i] = disp0 && (tail == PTR_W'(i));
    assign load_slot1[i] = disp1 && (slot1_ptr == PTR_W'(i));
    assign clear[i]      = (retire && (head == PTR_W'(i))) ||
                           (flush && ({1'b0, offset} >= cut) &&
                            !(keep_head && (head == PTR_W'(i))));

    lsq_entry u_entry (
      .clock      (clock),
      .reset      (reset),
      .clear      (clear[i]),
      .load_slot0 (load_slot0[i]),
      .load_slot1 (load_slot1[i]),
      .dispatch   (dispatch),
      .ex_wb      (ex_wb),
      .rob_head   (rob_head),
      .entry      (entries[i])
    );
  end

  //////////////////////////////
  // Pointers
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      head       <= '0;
      tail       <= '0;
      count      <= '0;
      commit_cnt <= '0;
    end else begin
      head       <= head + PTR_W'(retire);
      commit_cnt <= cut - (PTR_W+1)'(retire);
      if (flush) begin
        // Tail goes back to just past the surviving entries
        tail  <= head + cut[PTR_W-1:0] + PTR_W'(keep_head);
        count <= keep_head ? (PTR_W+1)'(1) : cut - (PTR_W+1)'(retire);
      end else begin
        tail  <= tail + n_disp[PTR_W-1:0];
        count <= count + n_disp - (PTR_W+1)'(retire);
      end
    end
  end

  assign dispatch_ready = (count <= (LSQ_DEPTH - 2));
  assign head_entry     = entries[head];

endmodule

// ==== src/lsq_mem_port.sv ====
// Sends the queue head to data memory and returns load data.
// One load may be outstanding; its response is dropped if a flush
// came while it was in flight.
module lsq_mem_port (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   flush,
  input  lsq_pkg::lsq_entry_t    head_entry,
  output logic                   retire,
  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output mem_bus_pkg::mem_req_t  mem_req,
  input  logic                   mem_resp_valid,
  input  mem_bus_pkg::mem_resp_t mem_resp,
  output lsq_pkg::load_result_t  load_result
);
  import lsq_pkg::*;
  import mem_bus_pkg::*;

  logic     outstanding;
  logic     drop;
  rob_tag_t out_tag;
  logic     head_ready;
  logic     issue;
  logic     resp_done;

  //////////////////////////////
  // Request side
  //////////////////////////////

  // Stores wait for their commit, loads only for the address
  assign head_ready = head_entry.valid && head_entry.addr_ready &&
                      (head_entry.is_load || head_entry.committed);

  assign mem_req_valid = head_ready && !outstanding;
  assign mem_req.cmd   = head_entry.is_load ? MEM_LOAD : MEM_STORE;
  assign mem_req.addr  = head_entry.addr;
  assign mem_req.data  = head_entry.data;

  assign issue     = mem_req_valid && mem_req_ready;
  assign resp_done = mem_resp_valid && outstanding;

  // Store leaves on its handshake, load on its response
  assign retire = (issue && !head_entry.is_load) || resp_done;

  //////////////////////////////
  // Response side
  //////////////////////////////

  assign load_result.valid = resp_done && !drop && !flush;
  assign load_result.tag   = out_tag;
  assign load_result.data  = mem_resp.data;

  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
      drop        <= 1'b0;
    end else begin
      if (resp_done) begin
        outstanding <= 1'b0;
      end else if (issue && head_entry.is_load) begin
        outstanding <= 1'b1;
      end
      // Also covers a ready head load the queue keeps across the flush
      if (resp_done) begin
        drop <= 1'b0;
      end else if (flush && (outstanding || (head_ready && head_entry.is_load))) begin
        drop <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue && head_entry.is_load) begin
      out_tag <= head_entry.tag;
    end
  end

endmodule

// ==== src/lsq_top.sv ====
// Load/store queue top level.
// Joins the entry queue to the data memory port.
module lsq_top (
  input  logic                   clock,
  input  logic                   reset,
  input  lsq_pkg::dispatch_t     dispatch [2],
  output logic                   dispatch_ready,
  input  lsq_pkg::ex_wb_t        ex_wb [2],
  input  lsq_pkg::rob_head_t     rob_head [2],
  input  logic                   flush,
  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output mem_bus_pkg::mem_req_t  mem_req,
  input  logic                   mem_resp_valid,
  input  mem_bus_pkg::mem_resp_t mem_resp,
  output lsq_pkg::load_result_t  load_result
);
  import lsq_pkg::*;

  lsq_entry_t head_entry;
  logic       retire;

  lsq_queue u_queue (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .retire         (retire),
    .dispatch       (dispatch),
    .ex_wb          (ex_wb),
    .rob_head       (rob_head),
    .dispatch_ready (dispatch_ready),
    .head_entry     (head_entry)
  );

  lsq_mem_port u_mem_port (
    .clock          (clock),
    .reset          (reset),
    .flush          (flush),
    .head_entry     (head_entry),
    .retire         (retire),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp       (mem_resp),
    .load_result    (load_result)
  );

endmodule

// ==== testbench/lsq_sva.sv ====
// Protocol assertions for the load/store queue top level.
// Bound to lsq_top from the testbench.
module lsq_sva (
  input logic                  clock,
  input logic                  reset,
  input logic                  mem_req_valid,
  input logic                  mem_req_ready,
  input mem_bus_pkg::mem_req_t mem_req,
  input lsq_pkg::rob_tag_t     head_tag,
  input lsq_pkg::rob_head_t    rob_head [2],
  input logic                  dispatch_ready,
  input logic                  disp_valid,
  input logic                  mem_resp_valid,
  input logic                  result_valid
);
  import lsq_pkg::*;
  import mem_bus_pkg::*;

  // Tags presented at a ROB head port since reset
  logic [2**TAG_W-1:0] head_seen;
  // Load accepted by memory and not yet answered
  logic                load_open;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_seen <= '0;
      load_open <= 1'b0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (rob_head[p].valid) begin
          head_seen[rob_head[p].tag] <= 1'b1;
        end
      end
      if (mem_resp_valid) begin
        load_open <= 1'b0;
      end else if (mem_req_valid && mem_req_ready && (mem_req.cmd == MEM_LOAD)) begin
        load_open <= 1'b1;
      end
    end
  end

  // Request held while memory stalls
  a_req_stable: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else $error("memory request changed while stalled");

  a_store_committed: assert property (@(posedge clock) disable iff (reset)
    mem_req_valid && (mem_req.cmd == MEM_STORE) |-> head_seen[head_tag])
    else $error("store sent to memory before commit");

  a_dispatch_ready: assert property (@(posedge clock) disable iff (reset)
    disp_valid |-> dispatch_ready)
    else $error("dispatch while dispatch_ready low");

  a_result_resp: assert property (@(posedge clock) disable iff (reset)
    result_valid |-> mem_resp_valid && load_open)
    else $error("load result without memory response");

endmodule

// ==== testbench/lsq_tb.sv ====
// Testbench for the load/store queue.
// Applies a table of dispatch, writeback, commit and flush rows and
// checks load results against a reference memory model.
module lsq_tb;
  import lsq_pkg::*;
  import mem_bus_pkg::*;

  localparam logic [4:0] F_LAST  = 5'b10000;
  localparam logic [4:0] F_FLUSH = 5'b01000;
  localparam logic [4:0] F_STALL = 5'b00100;
  localparam logic [4:0] F_CHK   = 5'b00010;
  localparam logic [4:0] F_RDY   = 5'b00001;

  typedef struct packed {
    logic [3:0] test;
    dispatch_t  d0;
    dispatch_t  d1;
    ex_wb_t     w0;
    ex_wb_t     w1;
    rob_head_t  h0;
    rob_head_t  h1;
    logic [4:0] flags;
  } row_t;

  logic clock, reset, flush, dispatch_ready;
  logic mem_req_valid, mem_req_ready, mem_resp_valid;
  dispatch_t    dispatch [2];
  ex_wb_t       ex_wb [2];
  rob_head_t    rob_head [2];
  mem_req_t     mem_req;
  mem_resp_t    mem_resp;
  load_result_t load_result;

  row_t         rows [$];
  load_result_t exp_q [$];
  rob_tag_t     order [$];
  logic [31:0]  mem [32];
  logic [31:0]  ref_mem [32];
  logic [31:0]  m_addr [32];
  logic [31:0]  m_data [32];
  logic         m_load [32];
  logic         m_ok [32];
  logic         m_com [32];
  logic [31:0]  seed = 32'd92754;
  logic         pend = 1'b0;
  int unsigned  wait_cnt = 0;
  logic [31:0]  rdata;
  int           cycles = 0;
  int           errors = 0;
  int           checks = 0;
  int           test_err = 0;

  lsq_top dut (.*);

  bind lsq_top lsq_sva sva (
    .clock          (clock),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req        (mem_req),
    .head_tag       (head_entry.tag),
    .rob_head       (rob_head),
    .dispatch_ready (dispatch_ready),
    .disp_valid     (dispatch[0].valid || dispatch[1].valid),
    .mem_resp_valid (mem_resp_valid),
    .result_valid   (load_result.valid)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [14:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:16];
  endfunction

  function automatic dispatch_t load_op(int tag);
    return '{valid: 1'b1, is_load: 1'b1, tag: rob_tag_t'(tag)};
  endfunction

  function automatic dispatch_t store_op(int tag);
    return '{valid: 1'b1, is_load: 1'b0, tag: rob_tag_t'(tag)};
  endfunction

  function automatic ex_wb_t writeback(int tag, logic [31:0] addr, logic [31:0] data);
    return '{valid: 1'b1, tag: rob_tag_t'(tag), addr: addr, data: data};
  endfunction

  function automatic rob_head_t head(int tag);
    return '{valid: 1'b1, tag: rob_tag_t'(tag)};
  endfunction

  task automatic add(int t, dispatch_t a, dispatch_t b, ex_wb_t x, ex_wb_t y,
                     rob_head_t g, rob_head_t k, logic [4:0] f);
    rows.push_back('{test: 4'(t), d0: a, d1: b, w0: x, w1: y, h0: g, h1: k, flags: f});
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always @(posedge clock) begin
    if (mem_resp_valid) pend = 1'b0;
    if (!reset && mem_req_valid && mem_req_ready) begin
      if (mem_req.cmd == MEM_STORE) begin
        mem[mem_req.addr[6:2]] = mem_req.data;
      end else begin
        pend     = 1'b1;
        wait_cnt = lcg_next() % 4;
        rdata    = mem[mem_req.addr[6:2]];
      end
    end
  end

  always @(negedge clock) begin
    mem_resp_valid = pend && (wait_cnt == 0);
    mem_resp.data  = rdata;
    if (pend && wait_cnt > 0) wait_cnt--;
  end

  //////////////////////////////
  // Result checking and timeout
  //////////////////////////////

  always @(posedge clock) begin
    load_result_t e;
    cycles++;
    if (load_result.valid) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        $display("ERR %0t: unexpected load result tag %0d", $time, load_result.tag);
        errors++;
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        assert (load_result.tag == e.tag && load_result.data == e.data) else begin
          $display("ERR %0t: load tag %0d data %h, expected tag %0d data %h", $time,
                   load_result.tag, load_result.data, e.tag, e.data);
          errors++;
        end
      end
    end
    if (cycles > rows.size() * 8 + 100) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // In-order reference where stores write on commit and loads read once ready
  task automatic model_row(row_t r);
    dispatch_t d [2];
    ex_wb_t    w [2];
    rob_head_t h [2];
    rob_tag_t  t;
    d = '{r.d0, r.d1};
    w = '{r.w0, r.w1};
    h = '{r.h0, r.h1};
    if (r.flags & F_FLUSH) begin
      exp_q.delete();
      order.delete();
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (d[p].valid) begin
          t = d[p].tag;
          m_load[t] = d[p].is_load;
          m_ok[t]   = 1'b0;
          m_com[t]  = 1'b0;
          order.push_back(t);
        end
      end
      for (int p = 0; p < 2; p++) begin
        if (w[p].valid) begin
          m_ok[w[p].tag]   = 1'b1;
          m_addr[w[p].tag] = w[p].addr;
          m_data[w[p].tag] = w[p].data;
        end
      end
      for (int p = 0; p < 2; p++) begin
        if (h[p].valid && m_ok[h[p].tag]) m_com[h[p].tag] = 1'b1;
      end
      while (order.size() > 0 && m_ok[order[0]] && (m_load[order[0]] || m_com[order[0]])) begin
        t = order.pop_front();
        if (m_load[t]) exp_q.push_back('{valid: 1'b1, tag: t, data: ref_mem[m_addr[t][6:2]]});
        else ref_mem[m_addr[t][6:2]] = m_data[t];
      end
    end
  endtask

  task automatic drive(row_t r);
    dispatch      = '{r.d0, r.d1};
    ex_wb         = '{r.w0, r.w1};
    rob_head      = '{r.h0, r.h1};
    flush         = |(r.flags & F_FLUSH);
    mem_req_ready = !(r.flags & F_STALL) && (lcg_next() % 8 != 0);
  endtask

  task automatic drain_test(int t);
    @(negedge clock);
    drive('0);
    while (exp_q.size() != 0 || dut.u_queue.count != 0) begin
      @(negedge clock);
      drive('0);
    end
    $display("test %0d done, %0d errors", t, errors - test_err);
    test_err = errors;
  endtask

  initial begin
    drive('0);
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    reset          = 1'b1;
    for (int i = 0; i < 32; i++) begin
      mem[i]     = (32'(i) + 1) * 32'h9e3779b9 ^ 32'(i);
      ref_mem[i] = mem[i];
    end
    // Test 2 store then load, 3 out-of-order writebacks, 4 late commit
    add(2, store_op(1), load_op(2), writeback(1, 'h10, 'hdead0001), writeback(2, 'h10, 0),
        head(1), '0, F_LAST);
    add(3, load_op(3), load_op(4), '0, '0, '0, '0, '0);
    add(3, load_op(5), load_op(6), writeback(6, 'h20, 0), writeback(4, 'h24, 0), '0, '0, '0);
    add(3, '0, '0, writeback(5, 'h28, 0), writeback(3, 'h2c, 0), '0, '0, F_LAST);
    add(4, store_op(7), load_op(8), writeback(7, 'h30, 'h12345678), writeback(8, 'h30, 0),
        '0, '0, '0);
    repeat (4) add(4, '0, '0, '0, '0, '0, '0, '0);
    add(4, '0, '0, '0, '0, head(7), '0, F_LAST);
    // Flush with a load in flight, then flush behind a committed store
    add(5, load_op(9), store_op(10), writeback(9, 'h40, 0), writeback(10, 'h44, 'hbad0bad0),
        '0, '0, '0);
    add(5, '0, '0, '0, '0, '0, '0, '0);
    add(5, '0, '0, '0, '0, '0, '0, F_FLUSH | F_LAST);
    add(6, store_op(11), '0, writeback(11, 'h48, 'hcafe0011), '0, head(11), '0, F_STALL);
    add(6, load_op(12), store_op(13), writeback(12, 'h48, 0), writeback(13, 'h48, 'hbad1),
        '0, '0, F_STALL);
    add(6, '0, '0, '0, '0, '0, '0, F_FLUSH | F_STALL);
    add(6, load_op(14), load_op(15), writeback(14, 'h48, 0), writeback(15, 'h44, 0),
        '0, '0, F_LAST);
    // Fill under a stalled memory until dispatch_ready drops
    for (int k = 0; k < 3; k++) begin
      add(7, load_op(16 + 2 * k), load_op(17 + 2 * k), writeback(16 + 2 * k, 4 * k, 0),
          writeback(17 + 2 * k, 4 * k + 'h60, 0), '0, '0, F_STALL | F_CHK | F_RDY);
    end
    add(7, load_op(22), '0, writeback(22, 'h58, 0), '0, '0, '0, F_STALL | F_CHK | F_RDY);
    add(7, '0, '0, '0, '0, '0, '0, F_STALL | F_CHK);
    add(7, '0, '0, '0, '0, '0, '0, F_STALL | F_CHK);
    repeat (11) add(7, '0, '0, '0, '0, '0, '0, '0);
    add(7, '0, '0, '0, '0, '0, '0, F_CHK | F_RDY | F_LAST);

    repeat (16) @(negedge clock);
    reset = 1'b0;
    checks++;
    assert (dispatch_ready && !mem_req_valid && !load_result.valid) else begin
      $display("ERR %0t: wrong outputs after reset", $time);
      errors++;
    end
    $display("test 1 done, %0d errors", errors);
    test_err = errors;
    foreach (rows[i]) begin
      @(negedge clock);
      if (rows[i].flags & F_CHK) begin
        checks++;
        assert (dispatch_ready == rows[i].flags[0]) else begin
          $display("ERR %0t: row %0d dispatch_ready %b", $time, i, dispatch_ready);
          errors++;
        end
      end
      drive(rows[i]);
      model_row(rows[i]);
      if (rows[i].flags & F_LAST) drain_test(rows[i].test);
    end
    $display("tests 7, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/lsq_pkg.sv
src/mem_bus_pkg.sv
src/lsq_entry.sv
src/lsq_queue.sv
src/lsq_mem_port.sv
src/lsq_top.sv
testbench/lsq_sva.sv
testbench/lsq_tb.sv

// ==== Bender.yml ====
package:
  name: lsq

sources:
  - files:
      - src/lsq_pkg.sv
      - src/mem_bus_pkg.sv
      - src/lsq_entry.sv
      - src/lsq_queue.sv
      - src/lsq_mem_port.sv
      - src/lsq_top.sv
  - target: test
    files:
      - testbench/lsq_sva.sv
      - testbench/lsq_tb.sv
